/* Makefile */
# Verilator build and run of the FIFO DMA testbench

VERILATOR ?= verilator
TOP       ?= tb_fifodma
RTL_TOP   ?= fifodma_top
FILELIST  ?= fifodma.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
LINTFLAGS ?= --lint-only --timing -Wall

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv include/*.svh test/*.sv)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the pass or fail result
run: $(SIM)
	./$(SIM)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* fifodma.f */
+incdir+include
source/fifodma_pkg.sv
source/fifodma_reg_bank.sv
source/fifodma_word_fifo.sv
source/fifodma_burst_writer.sv
source/fifodma_top.sv
test/tb_fifodma.sv

/* include/fifodma_settings.svh */
`ifndef FIFODMA_SETTINGS_SVH
`define FIFODMA_SETTINGS_SVH

// ------------------------------------------------
// bus and datapath widths
// ------------------------------------------------
`define FD_DATA_W        32     // register and psram data
`define FD_STRB_W        4      // byte strobes / mask bits
`define FD_REG_ADDR_W    12     // register byte address
`define FD_PS_ADDR_W     23     // psram byte address, 8MB

// ------------------------------------------------
// queue and burst shape
// ------------------------------------------------
`define FD_FIFO_DEPTH    16     // also the starting credit count
`define FD_BURST_WORDS   4      // beats per psram write burst
`define FD_TIMER_W       48     // free-running timer

// ------------------------------------------------
// register map, byte offsets
// ------------------------------------------------
`define FD_REG_TIMER_LO  12'h010
`define FD_REG_TIMER_HI  12'h014
`define FD_REG_WADRS     12'h030   // ring base
`define FD_REG_WAREA     12'h034   // ring size in bytes
`define FD_REG_WDATA     12'h038   // data port, write only
`define FD_REG_CTL       12'h03C
`define FD_REG_DEBUG     12'h040

`endif

/* source/fifodma_burst_writer.sv */
`timescale 1ns/1ps
`include "fifodma_settings.svh"

module fifodma_burst_writer
    import fifodma_pkg::*;
(
    input  logic       cpuclk,
    input  logic       WSHRST,
    input  ring_cfg_t  ring_cfg_i,
    input  logic       start_i,
    input  logic       end_i,
    input  data_t      head_i,
    input  logic       nonempty_i,
    input  fifo_cnt_t  count_i,
    input  logic       cmd_ready_i,
    output logic       pop_o,
    output logic       run_o,
    output logic       end_done_o,
    output psram_cmd_t psram_o
);

    localparam int BEAT_W      = $clog2(`FD_BURST_WORDS);
    localparam int BURST_BYTES = `FD_BURST_WORDS * 4;

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_WAIT  = 2'd1;   // collecting a full burst
    localparam logic [1:0] ST_BURST = 2'd2;   // beats 1..n-1
    localparam logic [1:0] ST_FLUSH = 2'd3;   // final partial burst

    logic [1:0]               state;
    logic                     pend_end;
    logic [BEAT_W-1:0]        beat_cnt;
    data_t                    offset;        // byte offset inside the ring
    data_t                    next_off;
    data_t                    cur_addr;
    logic [`FD_PS_ADDR_W-1:0] burst_addr;
    logic                     full_burst;
    logic                     issue;         // cmd_en cycle, first beat
    logic                     beat_act;
    logic                     last_beat;

    // ------------------------------------------------
    // burst decision
    // ------------------------------------------------
    assign full_burst = (count_i >= fifo_cnt_t'(`FD_BURST_WORDS));
    assign issue      = cmd_ready_i & ~start_i &
                        (((state == ST_WAIT) & full_burst) |
                         ((state == ST_FLUSH) & nonempty_i));
    assign beat_act   = issue | (state == ST_BURST);
    assign last_beat  = (state == ST_BURST) &
                        (beat_cnt == BEAT_W'(`FD_BURST_WORDS - 1));

    assign cur_addr = ring_cfg_i.base + offset;
    assign next_off = (offset + BURST_BYTES >= ring_cfg_i.size) ? '0
                                                                  : offset + BURST_BYTES;

    // ------------------------------------------------
    // psram port, empty fifo pads with a masked beat
    // ------------------------------------------------
    assign pop_o = beat_act & nonempty_i;

    always_comb begin
        psram_o        = '0;
        psram_o.cmd    = beat_act;                 // write only
        psram_o.cmd_en = issue;
        psram_o.addr   = (state == ST_BURST) ? burst_addr
                                             : cur_addr[`FD_PS_ADDR_W-1:0];
        if (beat_act) begin
            psram_o.wdata = nonempty_i ? head_i : '0;
            psram_o.mask  = nonempty_i ? '0 : '1;
        end
    end

    // ------------------------------------------------
    // fsm
    // ------------------------------------------------
    always_ff @(posedge cpuclk or posedge WSHRST) begin
        if (WSHRST) begin
            state      <= ST_IDLE;
            run_o      <= 1'b0;
            pend_end   <= 1'b0;
            beat_cnt   <= '0;
            offset     <= '0;
            end_done_o <= 1'b0;
        end else begin
            end_done_o <= 1'b0;
            if (end_i & run_o)
                pend_end <= 1'b1;          // latched until flushed
            if (issue) begin
                offset   <= next_off;      // next burst, wraps at ring end
                beat_cnt <= BEAT_W'(1);
                state    <= ST_BURST;
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (start_i) begin
                            offset   <= '0;
                            pend_end <= 1'b0;
                            run_o    <= 1'b1;
                            state    <= ST_WAIT;
                        end
                    end
                    ST_WAIT: begin
                        if (start_i) begin
                            offset   <= '0;    // rewind
                            pend_end <= 1'b0;
                        end else if (pend_end) begin
                            state <= ST_FLUSH;
                        end
                    end
                    ST_BURST: begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat)
                            state <= ST_WAIT;
                    end
                    default: begin         // flush, waits on ready if words left
                        if (~nonempty_i) begin
                            end_done_o <= 1'b1;
                            run_o      <= 1'b0;
                            pend_end   <= 1'b0;
                            state      <= ST_IDLE;
                        end
                    end
                endcase
            end
        end
    end

    // burst address held for the trailing beats
    always_ff @(posedge cpuclk) begin
        if (issue)
            burst_addr <= cur_addr[`FD_PS_ADDR_W-1:0];
    end

endmodule

/* source/fifodma_pkg.sv */
package fifodma_pkg;

`include "fifodma_settings.svh"

    typedef logic [`FD_DATA_W-1:0] data_t;

    // fifo occupancy and credit count, 0..depth inclusive
    typedef logic [$clog2(`FD_FIFO_DEPTH+1)-1:0] fifo_cnt_t;
    typedef logic [$clog2(`FD_FIFO_DEPTH)-1:0]   fifo_ptr_t;

    // register bus request, read when strb is all zero
    typedef struct packed {
        logic [`FD_REG_ADDR_W-1:0] addr;
        data_t                     wdata;
        logic [`FD_STRB_W-1:0]     strb;
        logic                      valid;
    } reg_req_t;

    // control word as software writes it
    typedef struct packed {
        logic [22:0] rsv_hi;
        logic        eflag_clr;     // 1 clears the sticky end flag
        logic [5:0]  rsv_lo;
        logic        end_req;       // flush and stop
        logic        start;         // rewind to base and run
    } ctl_wr_t;

    // control word as software reads it
    typedef struct packed {
        logic [14:0] zero_hi;
        logic        run;
        logic [6:0]  zero_mid;
        logic        eflag;
        logic [7:0]  zero_lo;
    } ctl_rd_t;

    typedef union packed {
        ctl_wr_t wr;
        ctl_rd_t rd;
    } ctl_word_u;

    // ring window, held static while the writer runs
    typedef struct packed {
        data_t base;
        data_t size;
    } ring_cfg_t;

    // psram command port, mask bit 1 = byte not written
    typedef struct packed {
        logic                     cmd;      // 1 = write
        logic                     cmd_en;
        logic [`FD_PS_ADDR_W-1:0] addr;
        data_t                    wdata;
        logic [`FD_STRB_W-1:0]    mask;
    } psram_cmd_t;

endpackage

/* source/fifodma_reg_bank.sv */
`timescale 1ns/1ps
`include "fifodma_settings.svh"

module fifodma_reg_bank
    import fifodma_pkg::*;
(
    input  logic      cpuclk,
    input  logic      WSHRST,
    input  reg_req_t  reg_req_i,
    input  logic      credit_ret_i,   // one per word popped
    input  logic      run_i,
    input  logic      end_done_i,
    output data_t     reg_rdata_o,
    output logic      reg_ready_o,
    output logic      push_o,
    output data_t     push_data_o,
    output ring_cfg_t ring_cfg_o,
    output logic      start_o,
    output logic      end_o
);

    // word offset match, byte lanes ignored
    function automatic logic reg_hit(input logic [`FD_REG_ADDR_W-1:0] adr,
                                     input logic [`FD_REG_ADDR_W-1:0] off);
        return adr[`FD_REG_ADDR_W-1:2] == off[`FD_REG_ADDR_W-1:2];
    endfunction

    logic                  wr_bus;
    logic                  rd_bus;
    logic                  wr_ok;
    logic                  no_credit;
    logic                  rstate;        // second cycle of a read
    fifo_cnt_t             credit;
    logic [`FD_TIMER_W-1:0] free_timer;
    logic                  eflag;
    data_t                 debug_q;
    data_t                 rd_mux;
    ctl_word_u             ctl_wr;
    ctl_word_u             ctl_rd;
    logic                  ctl_wen;
    logic                  wdata_wen;

    // ------------------------------------------------
    // bus handshake
    // ------------------------------------------------
    assign wr_bus    = reg_req_i.valid & (|reg_req_i.strb);
    assign rd_bus    = reg_req_i.valid & (reg_req_i.strb == '0);
    assign no_credit = (credit == '0);
    assign wr_ok     = wr_bus & ~no_credit;       // every write needs a credit

    // read stalls first cycle, write stalls while out of credit
    assign reg_ready_o = ~(rd_bus & ~rstate) & ~(wr_bus & no_credit);

    assign ctl_wen   = wr_ok & reg_hit(reg_req_i.addr, `FD_REG_CTL);
    assign wdata_wen = wr_ok & reg_hit(reg_req_i.addr, `FD_REG_WDATA);
    assign ctl_wr    = reg_req_i.wdata;           // write-side decode

    always_ff @(posedge cpuclk or posedge WSHRST) begin
        if (WSHRST)
            rstate <= 1'b0;
        else if (rstate)
            rstate <= 1'b0;
        else if (rd_bus)
            rstate <= 1'b1;
    end

    // ------------------------------------------------
    // configuration registers
    // ------------------------------------------------
    always_ff @(posedge cpuclk) begin
        if (wr_ok & reg_hit(reg_req_i.addr, `FD_REG_WADRS))
            ring_cfg_o.base <= reg_req_i.wdata;
        if (wr_ok & reg_hit(reg_req_i.addr, `FD_REG_WAREA))
            ring_cfg_o.size <= reg_req_i.wdata;
    end

    always_ff @(posedge cpuclk or posedge WSHRST) begin
        if (WSHRST)
            debug_q <= '0;
        else if (wr_ok & reg_hit(reg_req_i.addr, `FD_REG_DEBUG))
            debug_q <= reg_req_i.wdata;   // scratch for the logic analyzer
    end

    // data port, pushed one cycle after acceptance
    always_ff @(posedge cpuclk or posedge WSHRST) begin
        if (WSHRST)
            push_o <= 1'b0;
        else
            push_o <= wdata_wen;
    end

    always_ff @(posedge cpuclk) begin
        if (wdata_wen)
            push_data_o <= reg_req_i.wdata;
    end

    // control pulses, one cycle each
    always_ff @(posedge cpuclk or posedge WSHRST) begin
        if (WSHRST) begin
            start_o <= 1'b0;
            end_o   <= 1'b0;
        end else begin
            start_o <= ctl_wen & ctl_wr.wr.start;
            end_o   <= ctl_wen & ctl_wr.wr.end_req;
        end
    end

    // sticky end flag, set wins over write-1 clear
    always_ff @(posedge cpuclk or posedge WSHRST) begin
        if (WSHRST)
            eflag <= 1'b0;
        else if (end_done_i)
            eflag <= 1'b1;
        else if (ctl_wen & ctl_wr.wr.eflag_clr)
            eflag <= 1'b0;
    end

    // ------------------------------------------------
    // credit counter and free timer
    // ------------------------------------------------
    always_ff @(posedge cpuclk or posedge WSHRST) begin
        if (WSHRST)
            credit <= fifo_cnt_t'(`FD_FIFO_DEPTH);
        else
            credit <= credit + fifo_cnt_t'(credit_ret_i) - fifo_cnt_t'(wdata_wen);
    end

    always_ff @(posedge cpuclk or posedge WSHRST) begin
        if (WSHRST)
            free_timer <= '0;
        else
            free_timer <= free_timer + 1'b1;
    end

    // ------------------------------------------------
    // read mux, sampled in the first read cycle
    // ------------------------------------------------
    always_comb begin
        ctl_rd        = '0;           // unused bits read zero
        ctl_rd.rd.run   = run_i;
        ctl_rd.rd.eflag = eflag;
    end

    always_comb begin
        rd_mux = '0;                  // unmapped
        if (reg_hit(reg_req_i.addr, `FD_REG_TIMER_LO))
            rd_mux = free_timer[`FD_DATA_W-1:0];
        else if (reg_hit(reg_req_i.addr, `FD_REG_TIMER_HI))
            rd_mux = data_t'(free_timer[`FD_TIMER_W-1:`FD_DATA_W]);
        else if (reg_hit(reg_req_i.addr, `FD_REG_WADRS))
            rd_mux = ring_cfg_o.base;
        else if (reg_hit(reg_req_i.addr, `FD_REG_WAREA))
            rd_mux = ring_cfg_o.size;
        else if (reg_hit(reg_req_i.addr, `FD_REG_CTL))
            rd_mux = ctl_rd;
        else if (reg_hit(reg_req_i.addr, `FD_REG_DEBUG))
            rd_mux = debug_q;
    end

    always_ff @(posedge cpuclk) begin
        if (rd_bus & ~rstate)
            reg_rdata_o <= rd_mux;    // stable through the ready cycle
    end

endmodule

/* source/fifodma_top.sv */
`timescale 1ns/1ps
`include "fifodma_settings.svh"

module fifodma_top
    import fifodma_pkg::*;
(
    input  logic       cpuclk,
    input  logic       WSHRST,
    input  reg_req_t   reg_req_i,
    input  logic       cmd_ready_i,
    output data_t      reg_rdata_o,
    output logic       reg_ready_o,
    output psram_cmd_t psram_o
);

    // ------------------------------------------------
    // stage links
    // ------------------------------------------------
    logic      push;           // bank -> fifo
    data_t     push_data;
    logic      credit_ret;     // fifo -> bank
    data_t     head;           // fifo -> writer
    logic      nonempty;
    fifo_cnt_t count;
    logic      pop;            // writer -> fifo
    ring_cfg_t ring_cfg;       // bank -> writer
    logic      start_p;
    logic      end_p;
    logic      run;            // writer -> bank
    logic      end_done;

    fifodma_reg_bank u_reg_bank (
        .cpuclk       (cpuclk),
        .WSHRST       (WSHRST),
        .reg_req_i    (reg_req_i),
        .credit_ret_i (credit_ret),
        .run_i        (run),
        .end_done_i   (end_done),
        .reg_rdata_o  (reg_rdata_o),
        .reg_ready_o  (reg_ready_o),
        .push_o       (push),
        .push_data_o  (push_data),
        .ring_cfg_o   (ring_cfg),
        .start_o      (start_p),
        .end_o        (end_p)
    );

    fifodma_word_fifo u_word_fifo (
        .cpuclk       (cpuclk),
        .WSHRST       (WSHRST),
        .push_i       (push),
        .push_data_i  (push_data),
        .pop_i        (pop),
        .head_o       (head),
        .nonempty_o   (nonempty),
        .count_o      (count),
        .credit_ret_o (credit_ret)
    );

    fifodma_burst_writer u_burst_writer (
        .cpuclk       (cpuclk),
        .WSHRST       (WSHRST),
        .ring_cfg_i   (ring_cfg),
        .start_i      (start_p),
        .end_i        (end_p),
        .head_i       (head),
        .nonempty_i   (nonempty),
        .count_i      (count),
        .cmd_ready_i  (cmd_ready_i),
        .pop_o        (pop),
        .run_o        (run),
        .end_done_o   (end_done),
        .psram_o      (psram_o)
    );

endmodule

/* source/fifodma_word_fifo.sv */
`timescale 1ns/1ps
`include "fifodma_settings.svh"

module fifodma_word_fifo
    import fifodma_pkg::*;
(
    input  logic      cpuclk,
    input  logic      WSHRST,
    input  logic      push_i,
    input  data_t     push_data_i,
    input  logic      pop_i,
    output data_t     head_o,
    output logic      nonempty_o,
    output fifo_cnt_t count_o,
    output logic      credit_ret_o
);

    data_t     mem [`FD_FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    logic      do_pop;

    // ------------------------------------------------
    // queue storage, no overflow guard since credits bound it
    // ------------------------------------------------
    assign do_pop     = pop_i & nonempty_o;
    assign nonempty_o = (count_o != '0);
    assign head_o     = mem[rd_ptr];          // first-word fall-through

    always_ff @(posedge cpuclk) begin
        if (push_i)
            mem[wr_ptr] <= push_data_i;
    end

    // pointers wrap by width, depth is a power of two
    always_ff @(posedge cpuclk or posedge WSHRST) begin
        if (WSHRST) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_o <= '0;
        end else begin
            if (push_i)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            count_o <= count_o + fifo_cnt_t'(push_i) - fifo_cnt_t'(do_pop);
        end
    end

    // one credit back to the bank per word drained
    always_ff @(posedge cpuclk or posedge WSHRST) begin
        if (WSHRST)
            credit_ret_o <= 1'b0;
        else
            credit_ret_o <= do_pop;
    end

endmodule

/* test/fifodma_cases.txt */
# w offset data | r offset expected | t (timer_lo rises) | p offset expected (poll)
# b psram_addr data mask, beats in arrival order; all fields hex
# register readback, ring at 0x1000 of 32 bytes
w 030 00001000
w 034 00000020
w 040 a5a55a5a
r 030 00001000
r 034 00000020
r 040 a5a55a5a
r 050 00000000
r 03c 00000000
# free timer
t
t
r 014 00000000
# eight words, two bursts
w 03c 00000001
w 038 0a000001
w 038 0a000002
w 038 0a000003
w 038 0a000004
w 038 0a000005
w 038 0a000006
w 038 0a000007
w 038 0a000008
b 001000 0a000001 0
b 001004 0a000002 0
b 001008 0a000003 0
b 00100c 0a000004 0
b 001010 0a000005 0
b 001014 0a000006 0
b 001018 0a000007 0
b 00101c 0a000008 0
# third burst wraps to the base
w 038 0a000009
w 038 0a00000a
w 038 0a00000b
w 038 0a00000c
b 001000 0a000009 0
b 001004 0a00000a 0
b 001008 0a00000b 0
b 00100c 0a00000c 0
# end after six words, padded flush
w 03c 00000001
w 038 0b000001
w 038 0b000002
w 038 0b000003
w 038 0b000004
w 038 0b000005
w 038 0b000006
w 03c 00000002
b 001000 0b000001 0
b 001004 0b000002 0
b 001008 0b000003 0
b 00100c 0b000004 0
b 001010 0b000005 0
b 001014 0b000006 0
b 001018 00000000 f
b 00101c 00000000 f
p 03c 00000100
w 03c 00000100
r 03c 00000000
# twenty words under back-pressure
w 03c 00000001
r 03c 00010000
w 038 0c000001
w 038 0c000002
w 038 0c000003
w 038 0c000004
w 038 0c000005
w 038 0c000006
w 038 0c000007
w 038 0c000008
w 038 0c000009
w 038 0c00000a
w 038 0c00000b
w 038 0c00000c
w 038 0c00000d
w 038 0c00000e
w 038 0c00000f
w 038 0c000010
w 038 0c000011
w 038 0c000012
w 038 0c000013
w 038 0c000014
b 001000 0c000001 0
b 001004 0c000002 0
b 001008 0c000003 0
b 00100c 0c000004 0
b 001010 0c000005 0
b 001014 0c000006 0
b 001018 0c000007 0
b 00101c 0c000008 0
b 001000 0c000009 0
b 001004 0c00000a 0
b 001008 0c00000b 0
b 00100c 0c00000c 0
b 001010 0c00000d 0
b 001014 0c00000e 0
b 001018 0c00000f 0
b 00101c 0c000010 0
b 001000 0c000011 0
b 001004 0c000012 0
b 001008 0c000013 0
b 00100c 0c000014 0

/* test/tb_fifodma.sv */
`timescale 1ns/1ps
`include "fifodma_settings.svh"

module tb_fifodma
    import fifodma_pkg::*;
();

    localparam int    CLK_HALF   = 10;                       // 20 ns period
    localparam int    CASE_LIMIT = 200;                      // cycles allowed per case line
    localparam string CASES_FILE = "test/fifodma_cases.txt";

    // one parsed line of the cases file
    typedef struct packed {
        logic [7:0]  kind;      // w r t p b
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
    } case_t;

    // one beat as the psram model sees it
    typedef struct packed {
        logic [`FD_PS_ADDR_W-1:0] addr;
        data_t                    data;
        logic [`FD_STRB_W-1:0]    mask;
    } beat_t;

    logic       cpuclk;
    logic       WSHRST;
    reg_req_t   reg_req;
    logic       cmd_ready;
    data_t      reg_rdata;
    logic       reg_ready;
    psram_cmd_t psram;

    case_t  cases[$];
    beat_t  got_q[$];                     // captured beats, oldest first
    logic   cases_loaded = 1'b0;
    integer seed;
    int     beats_left   = 0;             // beats still due in the open burst
    int     beat_idx;
    logic [`FD_PS_ADDR_W-1:0] burst_addr;
    beat_t  cap;

    fifodma_top dut_i (
        .cpuclk      (cpuclk),
        .WSHRST      (WSHRST),
        .reg_req_i   (reg_req),
        .cmd_ready_i (cmd_ready),
        .reg_rdata_o (reg_rdata),
        .reg_ready_o (reg_ready),
        .psram_o     (psram)
    );

    initial begin
        cpuclk = 1'b0;
        forever #CLK_HALF cpuclk = ~cpuclk;
    end

    // ------------------------------------------------
    // reporting
    // ------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp,
                            input string what);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0d ns: %s, got %0h expected %0h",
                                $time, what, got, exp));
    endtask

    // ------------------------------------------------
    // register bus and cases file
    // ------------------------------------------------
    task automatic reg_write(input logic [31:0] off, input data_t data);
        @(posedge cpuclk);
        reg_req.addr  <= off[`FD_REG_ADDR_W-1:0];
        reg_req.wdata <= data;
        reg_req.strb  <= '1;
        reg_req.valid <= 1'b1;
        do
            @(posedge cpuclk);
        while (!reg_ready);                 // stalls while the bank has no credit
        reg_req.valid <= 1'b0;
        reg_req.strb  <= '0;
    endtask

    task automatic reg_read(input logic [31:0] off, output data_t data);
        @(posedge cpuclk);
        reg_req.addr  <= off[`FD_REG_ADDR_W-1:0];
        reg_req.strb  <= '0;                // all strobes low means read
        reg_req.valid <= 1'b1;
        do
            @(posedge cpuclk);
        while (!reg_ready);
        data = reg_rdata;                   // registered, stable in the ready cycle
        reg_req.valid <= 1'b0;
    endtask

    task automatic load_cases();
        integer           fd;
        integer           n;
        logic [63:0]      tok;
        logic [31:0]      fa;
        logic [31:0]      fb;
        logic [31:0]      fc;
        logic [8*200-1:0] rest;
        case_t            rec;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0)
            abort_run({"cannot open the cases file ", CASES_FILE});
        while ($fscanf(fd, "%s", tok) == 1) begin
            fa = '0;
            fb = '0;
            fc = '0;
            if (tok == "#") begin
                n = $fgets(rest, fd);       // rest of a comment line
            end else begin
                case (tok[7:0])
                    "t":     n = 0;         // no fields
                    "b":     n = $fscanf(fd, "%h %h %h", fa, fb, fc) - 3;
                    default: n = $fscanf(fd, "%h %h", fa, fb) - 2;
                endcase
                if (n != 0)
                    abort_run("malformed line in the cases file");
                rec = '{kind: tok[7:0], a: fa, b: fb, c: fc};
                cases.push_back(rec);
            end
        end
        $fclose(fd);
    endtask

    // next captured beat against one expected record
    task automatic expect_beat(input case_t rec);
        beat_t beat;
        do
            @(negedge cpuclk);
        while (got_q.size() == 0);
        beat = got_q.pop_front();
        check_eq(64'(beat.addr), 64'(rec.a), "psram beat address");
        check_eq(64'(beat.data), 64'(rec.b), "psram beat data");
        check_eq(64'(beat.mask), 64'(rec.c), "psram beat mask");
    endtask

    // ------------------------------------------------
    // psram model
    // ------------------------------------------------
    initial begin : ready_gen
        seed      = 32'h7018_56e4;
        cmd_ready = 1'b0;
        forever begin
            @(posedge cpuclk);
            cmd_ready <= (($random(seed) & 31) == 0);   // rarely ready, fifo backs up
        end
    end

    always @(posedge cpuclk) begin
        if (!WSHRST) begin
            if (psram.cmd_en) begin
                if (!cmd_ready)
                    abort_run("psram cmd_en was raised while cmd_ready was low");
                if (beats_left != 0)
                    abort_run("psram burst started before the previous one ended");
                check_eq(64'(psram.cmd), 64'd1, "psram command type at cmd_en");
                burst_addr = psram.addr;    // beats land at consecutive words
                beat_idx   = 0;
                beats_left = `FD_BURST_WORDS;
            end else if ((beats_left != 0) && !psram.cmd) begin
                abort_run("psram burst ended before all its beats arrived");
            end else if ((beats_left == 0) && psram.cmd) begin
                abort_run("psram write beat outside of a burst");
            end
            if (beats_left != 0) begin
                check_eq(64'(psram.addr), 64'(burst_addr),
                         "psram address held through the burst");
                cap.addr = burst_addr + `FD_PS_ADDR_W'(beat_idx * 4);
                cap.data = psram.wdata;
                cap.mask = psram.mask;
                got_q.push_back(cap);
                beat_idx   = beat_idx + 1;
                beats_left = beats_left - 1;
            end
        end
    end

    // ------------------------------------------------
    // watchdog and main sequence
    // ------------------------------------------------
    initial begin : watchdog
        wait (cases_loaded);
        repeat (cases.size() * CASE_LIMIT) @(posedge cpuclk);
        abort_run("timeout: the DUT stopped making progress through the cases");
    end

    initial begin : main
        data_t rd;
        data_t last_timer;
        WSHRST     = 1'b1;
        reg_req    = '0;
        last_timer = '0;
        load_cases();
        cases_loaded = 1'b1;
        repeat (3) @(posedge cpuclk);
        WSHRST <= 1'b0;

        foreach (cases[i]) begin
            case (cases[i].kind)
                "w": reg_write(cases[i].a, cases[i].b);
                "r": begin
                    reg_read(cases[i].a, rd);
                    check_eq(64'(rd), 64'(cases[i].b),
                             $sformatf("read of offset %h", cases[i].a[11:0]));
                end
                "t": begin
                    reg_read(`FD_REG_TIMER_LO, rd);
                    check_eq(64'(rd > last_timer), 64'd1, "timer_lo did not rise");
                    last_timer = rd;
                end
                "p": begin                  // poll until the flag settles
                    do
                        reg_read(cases[i].a, rd);
                    while (rd !== cases[i].b);
                end
                "b": expect_beat(cases[i]);
                default: abort_run("unknown record kind in the cases file");
            endcase
        end

        repeat (20) @(negedge cpuclk);      // room for a stray beat to show
        if ((got_q.size() != 0) || (beats_left != 0)) begin
            abort_run("psram received beats that no case expected");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule
